/* build.f */
common/rvfi_cmp_pkg.sv
rvfi_queue/rvfi_queue.sv
hdl/rvfi_field_cmp.sv
hdl/cmp_ctrl_fsm.sv
hdl/retire_gap_timer.sv
hdl/rvfi_step_compare.sv
dv/tb_clk_gen.sv
dv/tb_rvfi_step_compare.sv

/* common/rvfi_cmp_pkg.sv */
// ------------------------------
// shared types for the RVFI step-and-compare checker
// retirement record, field mask, result and FSM states
// ------------------------------

package rvfi_cmp_pkg;

  // default sizes for the top level parameters
  localparam int DEF_QUEUE_DEPTH = 4;
  localparam int DEF_GAP_LIMIT   = 64;

  // pair and mismatch counter width
  localparam int CNT_W = 16;

  // compared subset of one RVFI retirement
  typedef struct packed {
    logic [31:0] pc_rdata;
    logic [31:0] insn;
    logic        trap;
    logic        halt;
    logic [2:0]  dbg;
    logic        dbg_mode;
    logic        nmip;
    logic        intr;
    logic [1:0]  mode;
    logic [4:0]  rd1_addr;
    logic [31:0] rd1_wdata;
  } rvfi_rec_t;

  // set bit = field differs between core and model
  typedef struct packed {
    logic pc_rdata;
    logic insn;
    logic trap;
    logic halt;
    logic dbg;
    logic dbg_mode;
    logic nmip;
    logic intr;
    logic mode;
    logic rd1_addr;
    logic rd1_wdata;
  } field_mask_t;

  // one compare outcome tagged with the core pc
  typedef struct packed {
    logic        mismatch;
    field_mask_t mask;
    logic [31:0] pc_rdata;
  } cmp_result_t;

  // checker control states also exported as status
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    ST_RUN      = 3'd1,
    ST_FAIL     = 3'd2,
    ST_STALL    = 3'd3,
    ST_OVERFLOW = 3'd4
  } cmp_state_e;

endpackage

/* dv/tb_clk_gen.sv */
// ------------------------------
// testbench clock and reset
// 10 ns clock, 2-cycle reset
// ------------------------------
`timescale 1ns/10ps

module tb_clk_gen (
  input  logic restart_i,
  output logic clk_o,
  output logic arst_n_o
);

  logic [1:0] rst_cnt;

  initial begin
    clk_o   = 1'b0;
    rst_cnt = '0;
  end

  always #5 clk_o = ~clk_o;

  // reset held over two falling edges, released on a falling edge
  always @(negedge clk_o) begin
    if (restart_i) begin
      rst_cnt <= '0;
    end else if (rst_cnt != 2'd2) begin
      rst_cnt <= rst_cnt + 2'd1;
    end
  end

  assign arst_n_o = (rst_cnt == 2'd2);

endmodule

/* dv/tb_rvfi_step_compare.sv */
// ------------------------------
// testbench for the RVFI step-and-compare checker
// random stimulus, reference model, watchdog
// ------------------------------
`timescale 1ns/10ps

module tb_rvfi_step_compare;

  localparam int QUEUE_DEPTH = 4;
  localparam int GAP_LIMIT   = 16;
  localparam int NUM_TESTS   = 6;
  // 200 cycles per test plus one stall window
  localparam int TIMEOUT_CYC = NUM_TESTS * 200 + GAP_LIMIT;

  logic                           rvfi_rm;
  logic                           arst_n;
  logic                           restart;
  logic                           enable;
  logic                           stop;
  logic                           core_valid;
  logic                           rm_valid;
  rvfi_cmp_pkg::rvfi_rec_t        core_rec;
  rvfi_cmp_pkg::rvfi_rec_t        rm_rec;
  logic                           result_valid;
  rvfi_cmp_pkg::cmp_result_t      result;
  rvfi_cmp_pkg::cmp_state_e       state;
  logic [rvfi_cmp_pkg::CNT_W-1:0] pair_count;
  logic [rvfi_cmp_pkg::CNT_W-1:0] mismatch_count;

  // pairs in send order, read back by the compare process
  rvfi_cmp_pkg::rvfi_rec_t exp_core[$];
  rvfi_cmp_pkg::rvfi_rec_t exp_rm[$];
  string test_name;
  int    errors = 0;
  int    cmp_errors = 0;
  int    result_cnt = 0;
  int    exp_idx = 0;

  tb_clk_gen clk_gen_i (.restart_i(restart), .clk_o(rvfi_rm), .arst_n_o(arst_n));

  rvfi_step_compare #(.QUEUE_DEPTH(QUEUE_DEPTH), .GAP_LIMIT(GAP_LIMIT)) uut (
    .rvfi_rm           (rvfi_rm),
    .arst_n_i          (arst_n),
    .enable_i          (enable),
    .stop_on_mismatch_i(stop),
    .core_valid_i      (core_valid),
    .core_rec_i        (core_rec),
    .rm_valid_i        (rm_valid),
    .rm_rec_i          (rm_rec),
    .result_valid_o    (result_valid),
    .result_o          (result),
    .state_o           (state),
    .pair_count_o      (pair_count),
    .mismatch_count_o  (mismatch_count)
  );

  // expected outcome of one pair
  function automatic rvfi_cmp_pkg::cmp_result_t expected_result(
    input rvfi_cmp_pkg::rvfi_rec_t c, input rvfi_cmp_pkg::rvfi_rec_t r);
    rvfi_cmp_pkg::cmp_result_t res;
    logic                      rd1_checked;
    // rd1 only meaningful when neither side trapped
    rd1_checked        = !c.trap && !r.trap;
    res.mask.pc_rdata  = (c.pc_rdata != r.pc_rdata);
    res.mask.insn      = (c.insn != r.insn);
    res.mask.trap      = (c.trap != r.trap);
    res.mask.halt      = (c.halt != r.halt);
    res.mask.dbg       = (c.dbg != r.dbg);
    res.mask.dbg_mode  = (c.dbg_mode != r.dbg_mode);
    res.mask.nmip      = (c.nmip != r.nmip);
    res.mask.intr      = (c.intr != r.intr);
    res.mask.mode      = (c.mode != r.mode);
    res.mask.rd1_addr  = rd1_checked && (c.rd1_addr != r.rd1_addr);
    // writes to x0 carry no data
    res.mask.rd1_wdata = rd1_checked && (c.rd1_addr != 5'd0) && (c.rd1_wdata != r.rd1_wdata);
    res.mismatch       = (res.mask != '0);
    res.pc_rdata       = c.pc_rdata;
    return res;
  endfunction

  function automatic rvfi_cmp_pkg::rvfi_rec_t rand_rec();
    rvfi_cmp_pkg::rvfi_rec_t rec;
    logic [127:0]            bits;
    bits     = {$urandom, $urandom, $urandom, $urandom};
    rec      = bits[$bits(rvfi_cmp_pkg::rvfi_rec_t)-1:0];
    // traps are rarer than plain retires
    rec.trap = ($urandom % 4) == 0;
    return rec;
  endfunction

  function automatic rvfi_cmp_pkg::rvfi_rec_t flip_field(
    input rvfi_cmp_pkg::rvfi_rec_t r, input int unsigned sel);
    rvfi_cmp_pkg::rvfi_rec_t f;
    f = r;
    case (sel)
      0:       f.pc_rdata = ~f.pc_rdata;
      1:       f.insn     = ~f.insn;
      2:       f.trap     = ~f.trap;
      3:       f.halt     = ~f.halt;
      4:       f.dbg      = ~f.dbg;
      5:       f.dbg_mode = ~f.dbg_mode;
      6:       f.nmip     = ~f.nmip;
      7:       f.intr     = ~f.intr;
      8:       f.mode     = ~f.mode;
      9:       f.rd1_addr = ~f.rd1_addr;
      default: f.rd1_wdata = ~f.rd1_wdata;
    endcase
    return f;
  endfunction

  task automatic check_equal(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    assert (exp_val == act_val) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic check_state(input rvfi_cmp_pkg::cmp_state_e exp_state);
    assert (state == exp_state) else begin
      errors++;
      $display("%s: checker is in %s but should be in %s", test_name, state.name(),
               exp_state.name());
    end
  endtask

  // reset pulse from the clock generator, then idle outputs
  task automatic apply_reset(input string name);
    test_name = name;
    exp_core.delete();
    exp_rm.delete();
    @(negedge rvfi_rm);
    enable     = 1'b0;
    stop       = 1'b0;
    core_valid = 1'b0;
    rm_valid   = 1'b0;
    restart   <= 1'b1;
    @(negedge rvfi_rm);
    restart <= 1'b0;
    repeat (2) @(negedge rvfi_rm);
    check_state(rvfi_cmp_pkg::ST_IDLE);
    check_equal("result valid", 64'(0), 64'(result_valid));
    check_equal("pair count", 64'(0), 64'(pair_count));
    check_equal("mismatch count", 64'(0), 64'(mismatch_count));
  endtask

  // leader strobes first, follower off cycles later
  task automatic send_pair(input rvfi_cmp_pkg::rvfi_rec_t c, input rvfi_cmp_pkg::rvfi_rec_t r,
                           input int unsigned off, input int unsigned core_first);
    exp_core.push_back(c);
    exp_rm.push_back(r);
    for (int unsigned i = 0; i <= off; i++) begin
      @(negedge rvfi_rm);
      core_rec   = c;
      rm_rec     = r;
      core_valid = (core_first != 0) ? (i == 0) : (i == off);
      rm_valid   = (core_first != 0) ? (i == off) : (i == 0);
    end
    @(negedge rvfi_rm);
    core_valid = 1'b0;
    rm_valid   = 1'b0;
  endtask

  task automatic wait_pairs(input int n);
    while (pair_count != 16'(n)) begin
      @(negedge rvfi_rm);
    end
    check_equal("pairs left", 64'(0), 64'(exp_core.size() - exp_idx));
  endtask

  // compare each result against the next sent pair
  always @(negedge rvfi_rm) begin
    rvfi_cmp_pkg::cmp_result_t exp_res;
    if (!arst_n) begin
      exp_idx = 0;
    end else if (result_valid) begin
      result_cnt++;
      assert (exp_idx < exp_core.size()) else begin
        cmp_errors++;
        $display("%s: result pulse arrived with no pair outstanding", test_name);
      end
      if (exp_idx < exp_core.size()) begin
        exp_res = expected_result(exp_core[exp_idx], exp_rm[exp_idx]);
        exp_idx++;
        assert (result == exp_res) else begin
          cmp_errors++;
          $display("CHECK FAILED %s result: expected %0h, actual %0h", test_name, exp_res, result);
        end
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYC) @(posedge rvfi_rm);
    $display("watchdog expired in %s after %0d cycles", test_name, TIMEOUT_CYC);
    $display("run stopped: %0d errors, %0d result pulses", errors + cmp_errors, result_cnt);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    rvfi_cmp_pkg::rvfi_rec_t   c;
    rvfi_cmp_pkg::rvfi_rec_t   r;
    rvfi_cmp_pkg::cmp_result_t er;
    int                        n_bad;
    int                        base;
    int                        cycles;
    void'($urandom(32'h6ca8));
    restart    = 1'b0;
    enable     = 1'b0;
    stop       = 1'b0;
    core_valid = 1'b0;
    rm_valid   = 1'b0;
    core_rec   = '0;
    rm_rec     = '0;
    test_name  = "startup";

    // identical streams, random skew
    apply_reset("matching");
    enable = 1'b1;
    for (int i = 0; i < 12; i++) begin
      c = rand_rec();
      send_pair(c, c, $urandom % 4, $urandom % 2);
    end
    wait_pairs(12);
    check_equal("mismatch count", 64'(0), 64'(mismatch_count));
    check_state(rvfi_cmp_pkg::ST_RUN);

    // one field flipped in about half the pairs
    apply_reset("single_field");
    enable = 1'b1;
    n_bad  = 0;
    for (int i = 0; i < 12; i++) begin
      c = rand_rec();
      r = c;
      if ($urandom % 2 != 0) begin
        r = flip_field(c, $urandom % 11);
      end
      er = expected_result(c, r);
      if (er.mismatch) begin
        n_bad++;
      end
      send_pair(c, r, $urandom % 4, $urandom % 2);
    end
    wait_pairs(12);
    check_equal("mismatch count", 64'(n_bad), 64'(mismatch_count));
    check_state(rvfi_cmp_pkg::ST_RUN);

    // trap hides rd1, x0 hides write data
    apply_reset("masking");
    enable = 1'b1;
    c = rand_rec();
    c.trap = 1'b1;
    r = c;
    r.rd1_addr  = c.rd1_addr + 5'd1;
    r.rd1_wdata = ~c.rd1_wdata;
    send_pair(c, r, 0, 0);
    c = rand_rec();
    c.trap     = 1'b0;
    c.rd1_addr = '0;
    r = c;
    r.rd1_wdata = ~c.rd1_wdata;
    send_pair(c, r, 1, 1);
    wait_pairs(2);
    check_equal("mismatch count", 64'(0), 64'(mismatch_count));

    // third pair breaks the pc, later pairs must stay queued
    apply_reset("stop_on_mismatch");
    enable = 1'b1;
    stop   = 1'b1;
    base   = result_cnt;
    for (int i = 0; i < 5; i++) begin
      c = rand_rec();
      r = (i == 2) ? flip_field(c, 0) : c;
      send_pair(c, r, $urandom % 4, $urandom % 2);
    end
    repeat (10) @(negedge rvfi_rm);
    check_state(rvfi_cmp_pkg::ST_FAIL);
    check_equal("result pulses", 64'(3), 64'(result_cnt - base));
    check_equal("mismatch count", 64'(1), 64'(mismatch_count));

    // core retires, model silent
    apply_reset("stall");
    enable = 1'b1;
    @(negedge rvfi_rm);
    core_rec   = rand_rec();
    core_valid = 1'b1;
    @(negedge rvfi_rm);
    core_valid = 1'b0;
    cycles     = 1;
    while (state != rvfi_cmp_pkg::ST_STALL && cycles <= GAP_LIMIT + 2) begin
      @(negedge rvfi_rm);
      cycles++;
    end
    check_state(rvfi_cmp_pkg::ST_STALL);
    assert (cycles <= GAP_LIMIT + 2) else begin
      errors++;
      $display("%s: stall took %0d cycles, limit is %0d", test_name, cycles, GAP_LIMIT + 2);
    end

    // one strobe more than the queue holds, checker still idle
    apply_reset("overflow");
    for (int i = 0; i <= QUEUE_DEPTH; i++) begin
      @(negedge rvfi_rm);
      core_rec   = rand_rec();
      core_valid = 1'b1;
    end
    @(negedge rvfi_rm);
    core_valid = 1'b0;
    enable     = 1'b1;
    // idle to run, then run to overflow
    repeat (3) @(negedge rvfi_rm);
    check_state(rvfi_cmp_pkg::ST_OVERFLOW);

    $display("run done: %0d errors, %0d result pulses", errors + cmp_errors, result_cnt);
    if (errors + cmp_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* hdl/cmp_ctrl_fsm.sv */
// ------------------------------
// checker control FSM, pop strobe and status
// saturating pair and mismatch counters
// ------------------------------
`timescale 1ns/10ps

module cmp_ctrl_fsm (
  input  logic                           rvfi_rm,
  input  logic                           arst_n_i,
  input  logic                           enable_i,
  input  logic                           stop_on_mismatch_i,
  input  logic                           core_ready_i,
  input  logic                           rm_ready_i,
  input  logic                           core_ovf_i,
  input  logic                           rm_ovf_i,
  input  logic                           stall_i,
  input  logic                           result_valid_i,
  input  logic                           mismatch_i,
  output logic                           pop_o,
  output rvfi_cmp_pkg::cmp_state_e       state_o,
  output logic [rvfi_cmp_pkg::CNT_W-1:0] pair_count_o,
  output logic [rvfi_cmp_pkg::CNT_W-1:0] mismatch_count_o
);

  rvfi_cmp_pkg::cmp_state_e state_d;
  logic                     bad_result;

  assign bad_result = result_valid_i && mismatch_i;

  always_comb begin
    state_d = state_o;
    case (state_o)
      rvfi_cmp_pkg::ST_IDLE: begin
        if (enable_i) begin
          state_d = rvfi_cmp_pkg::ST_RUN;
        end
      end
      rvfi_cmp_pkg::ST_RUN: begin
        // lost records first, then stall, then mismatch
        if (core_ovf_i || rm_ovf_i) begin
          state_d = rvfi_cmp_pkg::ST_OVERFLOW;
        end else if (stall_i) begin
          state_d = rvfi_cmp_pkg::ST_STALL;
        end else if (bad_result && stop_on_mismatch_i) begin
          state_d = rvfi_cmp_pkg::ST_FAIL;
        end
      end
      // fail, stall and overflow hold until reset
      default: state_d = state_o;
    endcase
  end

  // no pop on the edge that leaves ST_RUN, so nothing more retires after a stop
  assign pop_o = (state_o == rvfi_cmp_pkg::ST_RUN) && (state_d == rvfi_cmp_pkg::ST_RUN) &&
                 core_ready_i && rm_ready_i;

  always_ff @(posedge rvfi_rm or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_o          <= rvfi_cmp_pkg::ST_IDLE;
      pair_count_o     <= '0;
      mismatch_count_o <= '0;
    end else begin
      state_o <= state_d;
      // counters stick at all ones
      if (result_valid_i && (pair_count_o != '1)) begin
        pair_count_o <= pair_count_o + 1'b1;
      end
      if (bad_result && (mismatch_count_o != '1)) begin
        mismatch_count_o <= mismatch_count_o + 1'b1;
      end
    end
  end

endmodule

/* hdl/retire_gap_timer.sv */
// ------------------------------
// retirement gap timer
// stall when one side stays silent too long
// ------------------------------
`timescale 1ns/10ps

module retire_gap_timer #(
  parameter int GAP_LIMIT = 64
) (
  input  logic rvfi_rm,
  input  logic arst_n_i,
  input  logic core_ready_i,
  input  logic rm_ready_i,
  output logic stall_o
);

  localparam int GAP_W = $clog2(GAP_LIMIT + 1);

  logic [GAP_W-1:0] gap_cnt_q;
  logic             one_sided;

  // exactly one queue holds records
  assign one_sided = core_ready_i ^ rm_ready_i;
  assign stall_o   = (gap_cnt_q == GAP_W'(GAP_LIMIT));

  always_ff @(posedge rvfi_rm or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gap_cnt_q <= '0;
    end else if (!one_sided) begin
      gap_cnt_q <= '0;
    end else if (!stall_o) begin
      // saturate at the limit
      gap_cnt_q <= gap_cnt_q + 1'b1;
    end
  end

endmodule

/* hdl/rvfi_field_cmp.sv */
// ------------------------------
// registered field compare of one core/model record pair
// applies trap and rd1 masking
// ------------------------------
`timescale 1ns/10ps

module rvfi_field_cmp (
  input  logic                      rvfi_rm,
  input  logic                      arst_n_i,
  input  logic                      sample_i,
  input  rvfi_cmp_pkg::rvfi_rec_t   core_i,
  input  rvfi_cmp_pkg::rvfi_rec_t   rm_i,
  output logic                      result_valid_o,
  output rvfi_cmp_pkg::cmp_result_t result_o
);

  rvfi_cmp_pkg::field_mask_t mask;
  logic                      any_trap;

  assign any_trap = core_i.trap || rm_i.trap;

  always_comb begin
    // plain field compares
    mask.pc_rdata = (core_i.pc_rdata != rm_i.pc_rdata);
    mask.insn     = (core_i.insn     != rm_i.insn);
    mask.trap     = (core_i.trap     != rm_i.trap);
    mask.halt     = (core_i.halt     != rm_i.halt);
    mask.dbg      = (core_i.dbg      != rm_i.dbg);
    mask.dbg_mode = (core_i.dbg_mode != rm_i.dbg_mode);
    mask.nmip     = (core_i.nmip     != rm_i.nmip);
    mask.intr     = (core_i.intr     != rm_i.intr);
    mask.mode     = (core_i.mode     != rm_i.mode);
    // rd1 is unreliable on a trap as core and model may differ
    mask.rd1_addr  = !any_trap && (core_i.rd1_addr != rm_i.rd1_addr);
    // x0 write data is don't care
    mask.rd1_wdata = !any_trap && (core_i.rd1_addr != '0) &&
                     (core_i.rd1_wdata != rm_i.rd1_wdata);
  end

  // result strobe one cycle after the pop
  always_ff @(posedge rvfi_rm or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_valid_o <= 1'b0;
    end else begin
      result_valid_o <= sample_i;
    end
  end

  // payload held until the next sample
  always_ff @(posedge rvfi_rm) begin
    if (sample_i) begin
      result_o.mismatch <= |mask;
      result_o.mask     <= mask;
      result_o.pc_rdata <= core_i.pc_rdata;
    end
  end

endmodule

/* hdl/rvfi_step_compare.sv */
// ------------------------------
// top of the RVFI step-and-compare checker
// two queues, comparator, control FSM, gap timer
// ------------------------------
`timescale 1ns/10ps

module rvfi_step_compare #(
  parameter int QUEUE_DEPTH = rvfi_cmp_pkg::DEF_QUEUE_DEPTH,
  parameter int GAP_LIMIT   = rvfi_cmp_pkg::DEF_GAP_LIMIT
) (
  input  logic                           rvfi_rm,
  input  logic                           arst_n_i,
  input  logic                           enable_i,
  input  logic                           stop_on_mismatch_i,
  input  logic                           core_valid_i,
  input  rvfi_cmp_pkg::rvfi_rec_t        core_rec_i,
  input  logic                           rm_valid_i,
  input  rvfi_cmp_pkg::rvfi_rec_t        rm_rec_i,
  output logic                           result_valid_o,
  output rvfi_cmp_pkg::cmp_result_t      result_o,
  output rvfi_cmp_pkg::cmp_state_e       state_o,
  output logic [rvfi_cmp_pkg::CNT_W-1:0] pair_count_o,
  output logic [rvfi_cmp_pkg::CNT_W-1:0] mismatch_count_o
);

  rvfi_cmp_pkg::rvfi_rec_t core_head;
  rvfi_cmp_pkg::rvfi_rec_t rm_head;
  logic                    core_ready;
  logic                    rm_ready;
  logic                    core_ovf;
  logic                    rm_ovf;
  logic                    pop;
  logic                    stall;

  // core side
  rvfi_queue #(.DEPTH(QUEUE_DEPTH)) core_queue_i (
    .rvfi_rm    (rvfi_rm),
    .arst_n_i   (arst_n_i),
    .push_i     (core_valid_i),
    .rec_i      (core_rec_i),
    .pop_i      (pop),
    .head_o     (core_head),
    .not_empty_o(core_ready),
    .overflow_o (core_ovf)
  );

  // reference model side
  rvfi_queue #(.DEPTH(QUEUE_DEPTH)) rm_queue_i (
    .rvfi_rm    (rvfi_rm),
    .arst_n_i   (arst_n_i),
    .push_i     (rm_valid_i),
    .rec_i      (rm_rec_i),
    .pop_i      (pop),
    .head_o     (rm_head),
    .not_empty_o(rm_ready),
    .overflow_o (rm_ovf)
  );

  // heads sampled on the shared pop
  rvfi_field_cmp field_cmp_i (
    .rvfi_rm       (rvfi_rm),
    .arst_n_i      (arst_n_i),
    .sample_i      (pop),
    .core_i        (core_head),
    .rm_i          (rm_head),
    .result_valid_o(result_valid_o),
    .result_o      (result_o)
  );

  cmp_ctrl_fsm ctrl_fsm_i (
    .rvfi_rm           (rvfi_rm),
    .arst_n_i          (arst_n_i),
    .enable_i          (enable_i),
    .stop_on_mismatch_i(stop_on_mismatch_i),
    .core_ready_i      (core_ready),
    .rm_ready_i        (rm_ready),
    .core_ovf_i        (core_ovf),
    .rm_ovf_i          (rm_ovf),
    .stall_i           (stall),
    .result_valid_i    (result_valid_o),
    .mismatch_i        (result_o.mismatch),
    .pop_o             (pop),
    .state_o           (state_o),
    .pair_count_o      (pair_count_o),
    .mismatch_count_o  (mismatch_count_o)
  );

  retire_gap_timer #(.GAP_LIMIT(GAP_LIMIT)) gap_timer_i (
    .rvfi_rm     (rvfi_rm),
    .arst_n_i    (arst_n_i),
    .core_ready_i(core_ready),
    .rm_ready_i  (rm_ready),
    .stall_o     (stall)
  );

endmodule

/* run.sh */
#!/bin/sh
# compile and run the checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_rvfi_step_compare -Mdir obj_dir -f build.f

./obj_dir/Vtb_rvfi_step_compare > sim.log
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
exit 1

/* rvfi_queue/rvfi_queue.sv */
// ------------------------------
// in-order queue of retirement records for one stream
// circular buffer with sticky overflow flag
// ------------------------------
`timescale 1ns/10ps

module rvfi_queue #(
  parameter int DEPTH = 4
) (
  input  logic                   rvfi_rm,
  input  logic                   arst_n_i,
  input  logic                   push_i,
  input  rvfi_cmp_pkg::rvfi_rec_t rec_i,
  input  logic                   pop_i,
  output rvfi_cmp_pkg::rvfi_rec_t head_o,
  output logic                   not_empty_o,
  output logic                   overflow_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int OCC_W = $clog2(DEPTH + 1);

  rvfi_cmp_pkg::rvfi_rec_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [OCC_W-1:0] occ_q;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  // explicit wrap since depth need not be a power of two
  function automatic logic [PTR_W-1:0] inc_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (occ_q == OCC_W'(DEPTH));
  assign not_empty_o = (occ_q != '0);
  // a pop in the same cycle frees a slot for the push
  assign pop_ok      = pop_i && not_empty_o;
  assign push_ok     = push_i && (!full || pop_ok);
  assign head_o      = mem[rd_ptr_q];

  // record storage
  always_ff @(posedge rvfi_rm) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= rec_i;
    end
  end

  always_ff @(posedge rvfi_rm or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      occ_q      <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= inc_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= inc_ptr(rd_ptr_q);
      end
      // occupancy only moves when exactly one side acts
      if (push_ok && !pop_ok) begin
        occ_q <= occ_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        occ_q <= occ_q - 1'b1;
      end
      // a dropped record sets the sticky flag as RVFI cannot be stalled
      if (push_i && !push_ok) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule
